// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_despreader_top
FILELIST  ?= despreader_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJ_DIR)

// ==== bench/despreader_model.svh ====
/* despreader reference model
   register image, per-channel code, timing and slip state,
   stepped once per clock, with expected dump sums queued. */
`ifndef DESPREADER_MODEL_SVH
`define DESPREADER_MODEL_SVH

logic [31:0]             img [15];  // 0 global, 1..7 channel a, 8..14 channel b.
logic [17:0]             m_state [2];
logic [17:0]             m_idx [2];
logic [15:0]             m_integ [2];
logic [7:0]              m_dwell [2];
logic                    m_auto [2];
logic                    m_req [2];
logic                    m_ack [2];
logic                    exp_epoch [2];
logic signed [ACC_W-1:0] m_acc_i [2];
logic signed [ACC_W-1:0] m_acc_q [2];
logic [2*ACC_W-1:0]      exp_a [$];
logic [2*ACC_W-1:0]      exp_b [$];
int                      m_auto_slips;

function automatic int reg_index(input logic [11:0] a);
    if (a == 12'h000) return 0;
    if ((a[11:8] == 4'h1 || a[11:8] == 4'h2) && a[7:0] <= 8'h18 && a[1:0] == 2'b00)
        return 1 + (int'(a[11:8]) - 1) * 7 + int'(a[7:2]);
    return -1;
endfunction

function automatic logic [31:0] field_mask(input int k);
    if (k == 0) return 32'h8000_FF03;  // manual slip, dwell, mode.
    if (k == 6 || k == 13) return 32'h0000_000F;
    return 32'h0003_FFFF;
endfunction

function automatic logic [31:0] reg_read(input logic [11:0] a);
    int k;
    k = reg_index(a);
    if (k < 0) return 32'h0;
    return img[k];
endfunction

function automatic logic [17:0] fld(input int ch, input int off);
    return img[1 + ch * 7 + off][17:0];
endfunction

task automatic model_reset();
    for (int k = 0; k < 15; k++) img[k] = '0;
    for (int ch = 0; ch < 2; ch++) begin
        m_state[ch] = '0;
        m_idx[ch] = '0;
        m_integ[ch] = '0;
        m_dwell[ch] = '0;
        m_auto[ch] = 1'b0;
        m_req[ch] = 1'b0;
        m_ack[ch] = 1'b0;
        exp_epoch[ch] = 1'b0;
        m_acc_i[ch] = '0;
        m_acc_q[ch] = '0;
    end
    m_auto_slips = 0;
endtask

task automatic model_write(input logic [3:0] w, input logic [11:0] a, input logic [31:0] d);
    int          k;
    logic [31:0] m;
    k = reg_index(a);
    if (k >= 0) begin
        m = {{8{w[3]}}, {8{w[2]}}, {8{w[1]}}, {8{w[0]}}} & field_mask(k);
        img[k] = (img[k] & ~m) | (d & m);
    end
endtask

// one clock edge of a channel, from the values before the edge.
task automatic gen_step(input int ch, input logic sv, input logic signed [7:0] si,
                        input logic signed [7:0] sq, input logic slip_wr);
    despread_pkg::ctrl_word_u g;
    despread_pkg::ctrl_word_u c;
    logic                     en, slip, accept, dump, ci, cq, next_ack;
    logic signed [ACC_W-1:0]  vi, vq;
    g = img[0];
    c = img[6 + 7 * ch];
    en = g.gbl.despread_mode == despread_pkg::MODE_BOTH ||
         g.gbl.despread_mode == (ch == 0 ? despread_pkg::MODE_A : despread_pkg::MODE_B);
    slip = sv && en && ((m_req[ch] && !m_ack[ch]) || m_auto[ch]);
    accept = sv && en && !slip;
    exp_epoch[ch] = accept && m_idx[ch] == fld(ch, 6);
    next_ack = m_req[ch] && (m_ack[ch] || slip);
    m_req[ch] = !m_ack[ch] && (m_req[ch] || slip_wr);
    m_ack[ch] = next_ack;
    if (!en) begin
        m_state[ch] = fld(ch, 0);
        m_idx[ch] = '0;
        m_integ[ch] = '0;
        m_dwell[ch] = '0;
        m_auto[ch] = 1'b0;
        m_acc_i[ch] = '0;
        m_acc_q[ch] = '0;
    end else if (slip) begin
        if (m_auto[ch]) m_auto_slips++;
        m_auto[ch] = 1'b0;
    end else if (accept) begin
        ci = ^(m_state[ch] & fld(ch, 3));
        cq = ^(m_state[ch] & fld(ch, 4));
        vi = ACC_W'(si);
        vq = ACC_W'(sq);
        m_acc_i[ch] = m_acc_i[ch] + (ci ? -vi : vi);
        m_acc_q[ch] = m_acc_q[ch] + (cq ? -vq : vq);
        dump = m_integ[ch] == 16'((1 << c.chan.corr_length) - 1);
        if (m_idx[ch] == fld(ch, 2)) begin
            m_state[ch] = fld(ch, 0);
            m_idx[ch] = '0;
        end else begin
            m_state[ch] = {m_state[ch][16:0], ^(m_state[ch] & fld(ch, 1))};
            m_idx[ch] = m_idx[ch] + 18'd1;
        end
        if (dump) begin
            if (ch == 0) exp_a.push_back({m_acc_i[ch], m_acc_q[ch]});
            else exp_b.push_back({m_acc_i[ch], m_acc_q[ch]});
            m_acc_i[ch] = '0;
            m_acc_q[ch] = '0;
            m_integ[ch] = '0;
            if (m_dwell[ch] == g.gbl.dwell_count) begin
                m_dwell[ch] = '0;
                m_auto[ch] = !g.gbl.manual_slip;
            end else begin
                m_dwell[ch] = m_dwell[ch] + 8'd1;
            end
        end else begin
            m_integ[ch] = m_integ[ch] + 16'd1;
        end
    end
endtask

`endif

// ==== bench/tb_despreader_top.sv ====
/* despreader testbench
   random register traffic and sample streams on both channels,
   checked cycle by cycle against a reference model. */
`timescale 1ns/1ps

module tb_despreader_top;

    localparam int ACC_W = 24;

    logic                    clk, arst_n, cs, sample_valid;
    logic [3:0]              wr;
    logic [11:0]             addr;
    logic [31:0]             din, dout;
    logic signed [7:0]       sample_i, sample_q;
    logic                    corr_valid_a, corr_valid_b, epoch_a, epoch_b;
    logic signed [ACC_W-1:0] corr_i_a, corr_q_a, corr_i_b, corr_q_b;
    int                      seed = 42032;
    int                      err_count = 0;
    int                      timeout_count = 0;
    int                      n_dumps = 0;

    `include "despreader_model.svh"

    despreader_top #(.ACC_W(ACC_W)) i_dut (
        .clk          (clk),
        .arst_n       (arst_n),
        .cs           (cs),
        .wr           (wr),
        .addr         (addr),
        .din          (din),
        .dout         (dout),
        .sample_valid (sample_valid),
        .sample_i     (sample_i),
        .sample_q     (sample_q),
        .corr_valid_a (corr_valid_a),
        .corr_i_a     (corr_i_a),
        .corr_q_a     (corr_q_a),
        .epoch_a      (epoch_a),
        .corr_valid_b (corr_valid_b),
        .corr_i_b     (corr_i_b),
        .corr_q_b     (corr_q_b),
        .epoch_b      (epoch_b)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'((r & 32'h7FFF_FFFF) % n);
    endfunction

    function automatic logic [11:0] addr_of(input int k);
        if (k == 0) return 12'h000;
        return 12'((k <= 7 ? 32'h100 : 32'h200) + ((k - 1) % 7) * 4);
    endfunction

    task automatic check_dump(input int ch, input logic signed [ACC_W-1:0] ci,
                              input logic signed [ACC_W-1:0] cq);
        logic [2*ACC_W-1:0] e;
        logic               have;
        string              name;
        name = ch == 0 ? "A" : "B";
        have = 1'b0;
        if (ch == 0 && exp_a.size() > 0) begin
            e = exp_a.pop_front();
            have = 1'b1;
        end
        if (ch == 1 && exp_b.size() > 0) begin
            e = exp_b.pop_front();
            have = 1'b1;
        end
        assert (have) else begin
            err_count++;
            $display("channel %s gave a dump at %0t that was not expected", name, $time);
        end
        if (have) begin
            n_dumps++;
            assert ({ci, cq} == e) else begin
                err_count++;
                $display("ERR %0t: channel %s dump i=%0d q=%0d, expected i=%0d q=%0d",
                         $time, name, ci, cq, $signed(e[2*ACC_W-1:ACC_W]),
                         $signed(e[ACC_W-1:0]));
            end
        end
    endtask

    // outputs here follow the inputs driven one cycle earlier.
    task automatic check_outputs();
        logic [31:0] exp_dout;
        exp_dout = cs ? reg_read(addr) : 32'h0;
        assert (dout == exp_dout) else begin
            err_count++;
            $display("ERR %0t: dout at addr %h is %h, expected %h", $time, addr, dout, exp_dout);
        end
        assert (epoch_a == exp_epoch[0] && epoch_b == exp_epoch[1]) else begin
            err_count++;
            $display("ERR %0t: epoch a/b is %b%b, expected %b%b", $time,
                     epoch_a, epoch_b, exp_epoch[0], exp_epoch[1]);
        end
        if (corr_valid_a) check_dump(0, corr_i_a, corr_q_a);
        if (corr_valid_b) check_dump(1, corr_i_b, corr_q_b);
    endtask

    task automatic tick(input logic c, input logic [3:0] w, input logic [11:0] a,
                        input logic [31:0] d, input logic v);
        logic signed [7:0] si, sq;
        @(negedge clk);
        check_outputs();
        si = 8'($random(seed));
        sq = 8'($random(seed));
        cs = c;
        wr = w;
        addr = a;
        din = d;
        sample_valid = v;
        sample_i = si;
        sample_q = sq;
        gen_step(0, v, si, sq, c && w[3] && a == despread_pkg::ADDR_CONTROL_A);
        gen_step(1, v, si, sq, c && w[3] && a == despread_pkg::ADDR_CONTROL_B);
        if (c) model_write(w, a, d);
    endtask

    task automatic set_global(input despread_pkg::despread_mode_e mode, input logic manual,
                              input logic [7:0] dwell);
        despread_pkg::ctrl_word_u u;
        u = '0;
        u.gbl.manual_slip = manual;
        u.gbl.dwell_count = dwell;
        u.gbl.despread_mode = mode;
        tick(1'b1, 4'b1011, despread_pkg::ADDR_CONTROL, u, 1'b0);
    endtask

    task automatic config_channel(input int ch);
        logic [11:0] base;
        int          restart;
        base = ch == 0 ? 12'h100 : 12'h200;
        restart = 8 + rand_below(56);
        tick(1'b1, 4'b0111, base, $random(seed) | 32'h1, 1'b0);
        tick(1'b1, 4'b0111, base + 12'h004, $random(seed), 1'b0);
        tick(1'b1, 4'b0111, base + 12'h008, 32'(restart), 1'b0);
        tick(1'b1, 4'b0111, base + 12'h00C, $random(seed), 1'b0);
        tick(1'b1, 4'b0111, base + 12'h010, $random(seed), 1'b0);
        tick(1'b1, 4'b0111, base + 12'h018, 32'(rand_below(restart + 1)), 1'b0);
        tick(1'b1, 4'b0001, base + 12'h014, 32'(rand_below(6)), 1'b0);  // corr length.
    endtask

    task automatic run_samples(input int n);
        for (int i = 0; i < n; i++) tick(1'b0, 4'h0, 12'h000, 32'h0, rand_below(4) != 0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((exp_a.size() > 0 || exp_b.size() > 0) && n < 50) begin
            tick(1'b0, 4'h0, 12'h000, 32'h0, 1'b0);
            n++;
        end
        if (exp_a.size() > 0 || exp_b.size() > 0) begin
            timeout_count++;
            $display("timeout: expected dumps never arrived (a %0d, b %0d left)",
                     exp_a.size(), exp_b.size());
        end
    endtask

    initial begin
        logic [11:0] a;
        int          k;
        cs = 1'b0;
        wr = 4'h0;
        addr = '0;
        din = '0;
        sample_valid = 1'b0;
        sample_i = '0;
        sample_q = '0;
        arst_n = 1'b0;
        model_reset();
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // register map, lanes, unmapped space and cs low.
        for (k = 0; k < 15; k++) tick(1'b1, 4'h0, addr_of(k), 32'h0, 1'b0);
        for (int i = 0; i < 150; i++) begin
            k = rand_below(18);
            a = k < 15 ? addr_of(k) : 12'($random(seed));
            tick(1'b1, 4'($random(seed)), a, $random(seed), 1'b0);
            tick(1'b1, 4'h0, a, 32'h0, 1'b0);
            tick(1'b0, 4'hF, addr_of(rand_below(15)), $random(seed), 1'b0);
        end

        // channel a alone.
        set_global(despread_pkg::MODE_OFF, 1'b1, 8'h0);
        config_channel(0);
        set_global(despread_pkg::MODE_A, 1'b1, 8'(rand_below(4)));
        run_samples(400);
        drain();

        // both channels on the same samples.
        set_global(despread_pkg::MODE_OFF, 1'b1, 8'h0);
        config_channel(0);
        config_channel(1);
        set_global(despread_pkg::MODE_BOTH, 1'b1, 8'(rand_below(4)));
        run_samples(600);

        // requested slips, one channel at a time.
        for (int i = 0; i < 6; i++) begin
            tick(1'b1, 4'b1000, i % 2 == 0 ? despread_pkg::ADDR_CONTROL_A :
                 despread_pkg::ADDR_CONTROL_B, $random(seed), 1'b0);
            run_samples(40);
        end
        drain();

        // dwell-driven slips.
        set_global(despread_pkg::MODE_BOTH, 1'b0, 8'(rand_below(4)));
        run_samples(800);

        // off mid-run, then back on from init.
        set_global(despread_pkg::MODE_OFF, 1'b0, 8'h1);
        run_samples(60);
        set_global(despread_pkg::MODE_BOTH, 1'b0, 8'h1);
        run_samples(300);
        drain();

        assert (n_dumps > 0 && m_auto_slips > 0) else begin
            err_count++;
            $display("the run produced no dumps or no automatic slips to check");
        end
        $display("errors: %0d mismatches, %0d timeouts, %0d dumps checked",
                 err_count, timeout_count, n_dumps);
        if (err_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== code_gen/code_gen.sv ====
/* code generator
   one channel's lfsr code with restart, epoch marker, integration
   dump timing, and requested or dwell-driven code slip. */
`timescale 1ns/1ps

module code_gen (
    input  logic                                     clk,
    input  logic                                     arst_n,
    code_cfg_if.gen                                  cfg,
    input  logic                                     sample_valid,
    input  logic signed [despread_pkg::SAMPLE_W-1:0] sample_i_in,
    input  logic signed [despread_pkg::SAMPLE_W-1:0] sample_q_in,
    output logic                                     chip_valid,
    output logic                                     chip_i,
    output logic                                     chip_q,
    output logic                                     dump,
    output logic                                     epoch,
    output logic signed [despread_pkg::SAMPLE_W-1:0] sample_i,
    output logic signed [despread_pkg::SAMPLE_W-1:0] sample_q
);

    localparam int W     = despread_pkg::LFSR_W;
    localparam int INT_W = 2 ** despread_pkg::CORR_LEN_W;

    logic [W-1:0]                     state, idx;
    logic [INT_W-1:0]                 integ, integ_last;
    logic [despread_pkg::DWELL_W-1:0] dwell;
    logic                             auto_slip, manual_pend, slip, accept, last_chip;

    assign integ_last  = ~({INT_W{1'b1}} << cfg.corr_length);
    assign last_chip   = integ == integ_last;
    assign manual_pend = cfg.slip_req && !cfg.slip_ack;
    assign slip        = sample_valid && cfg.enable && (manual_pend || auto_slip);
    assign accept      = sample_valid && cfg.enable && !slip;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= '0;
            idx       <= '0;
            integ     <= '0;
            dwell     <= '0;
            auto_slip <= 1'b0;
        end else if (!cfg.enable) begin
            state     <= cfg.init;  // parked at start of code.
            idx       <= '0;
            integ     <= '0;
            dwell     <= '0;
            auto_slip <= 1'b0;
        end else if (slip) begin
            auto_slip <= 1'b0;      // sample dropped, nothing advances.
        end else if (accept) begin
            if (idx == cfg.restart_count) begin
                state <= cfg.init;
                idx   <= '0;
            end else begin
                state <= {state[W-2:0], ^(state & cfg.poly_taps)};
                idx   <= idx + 1'b1;
            end
            if (last_chip) begin
                integ <= '0;
                if (dwell == cfg.dwell_count) begin
                    dwell     <= '0;
                    auto_slip <= !cfg.manual_slip;
                end else begin
                    dwell <= dwell + 1'b1;
                end
            end else begin
                integ <= integ + 1'b1;
            end
        end
    end

    // ack once the slip is taken, release after req drops.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg.slip_ack <= 1'b0;
        end else if (!cfg.slip_req) begin
            cfg.slip_ack <= 1'b0;
        end else if (slip) begin
            cfg.slip_ack <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            chip_valid <= 1'b0;
            dump       <= 1'b0;
            epoch      <= 1'b0;
        end else begin
            chip_valid <= accept;
            dump       <= accept && last_chip;
            epoch      <= accept && idx == cfg.epoch;
        end
    end

    always_ff @(posedge clk) begin
        chip_i   <= ^(state & cfg.i_out_taps);
        chip_q   <= ^(state & cfg.q_out_taps);
        sample_i <= sample_i_in;
        sample_q <= sample_q_in;
    end

endmodule

// ==== common/code_cfg_if.sv ====
/* code channel configuration
   carries one channel's settings and the four-phase slip
   handshake from the register set to its code generator. */
`timescale 1ns/1ps

interface code_cfg_if;

    logic [despread_pkg::LFSR_W-1:0]     init;
    logic [despread_pkg::LFSR_W-1:0]     poly_taps;
    logic [despread_pkg::LFSR_W-1:0]     restart_count;
    logic [despread_pkg::LFSR_W-1:0]     i_out_taps;
    logic [despread_pkg::LFSR_W-1:0]     q_out_taps;
    logic [despread_pkg::LFSR_W-1:0]     epoch;
    logic [despread_pkg::CORR_LEN_W-1:0] corr_length;
    logic [despread_pkg::DWELL_W-1:0]    dwell_count;
    logic                                manual_slip;
    logic                                enable;
    logic                                slip_req;
    logic                                slip_ack;

    modport regs (
        output init, poly_taps, restart_count, i_out_taps, q_out_taps, epoch,
        output corr_length, dwell_count, manual_slip, enable, slip_req,
        input  slip_ack
    );

    modport gen (
        input  init, poly_taps, restart_count, i_out_taps, q_out_taps, epoch,
        input  corr_length, dwell_count, manual_slip, enable, slip_req,
        output slip_ack
    );

endinterface

// ==== common/despread_pkg.sv ====
/* despread package
   shared widths, register address map, mode encoding and the
   two decodings of a control register word. */

package despread_pkg;

    localparam int LFSR_W     = 18;
    localparam int ADDR_W     = 12;
    localparam int DATA_W     = 32;
    localparam int SAMPLE_W   = 8;
    localparam int CORR_LEN_W = 4;  // period is 2**corr_length chips.
    localparam int DWELL_W    = 8;

    localparam logic [ADDR_W-1:0] ADDR_CONTROL = 12'h000;

    localparam logic [ADDR_W-1:0] ADDR_INIT_A          = 12'h100;
    localparam logic [ADDR_W-1:0] ADDR_POLY_TAPS_A     = 12'h104;
    localparam logic [ADDR_W-1:0] ADDR_RESTART_COUNT_A = 12'h108;
    localparam logic [ADDR_W-1:0] ADDR_I_OUT_TAPS_A    = 12'h10C;
    localparam logic [ADDR_W-1:0] ADDR_Q_OUT_TAPS_A    = 12'h110;
    localparam logic [ADDR_W-1:0] ADDR_CONTROL_A       = 12'h114;
    localparam logic [ADDR_W-1:0] ADDR_EPOCH_A         = 12'h118;

    localparam logic [ADDR_W-1:0] ADDR_INIT_B          = 12'h200;
    localparam logic [ADDR_W-1:0] ADDR_POLY_TAPS_B     = 12'h204;
    localparam logic [ADDR_W-1:0] ADDR_RESTART_COUNT_B = 12'h208;
    localparam logic [ADDR_W-1:0] ADDR_I_OUT_TAPS_B    = 12'h20C;
    localparam logic [ADDR_W-1:0] ADDR_Q_OUT_TAPS_B    = 12'h210;
    localparam logic [ADDR_W-1:0] ADDR_CONTROL_B       = 12'h214;
    localparam logic [ADDR_W-1:0] ADDR_EPOCH_B         = 12'h218;

    typedef enum logic [1:0] {
        MODE_OFF  = 2'd0,
        MODE_A    = 2'd1,
        MODE_B    = 2'd2,
        MODE_BOTH = 2'd3
    } despread_mode_e;

    // global control word.
    typedef struct packed {
        logic                 manual_slip;
        logic [14:0]          rsvd_hi;
        logic [DWELL_W-1:0]   dwell_count;
        logic [5:0]           rsvd_lo;
        despread_mode_e       despread_mode;
    } ctrl_global_t;

    // channel control word.
    typedef struct packed {
        logic [27:0]           rsvd;
        logic [CORR_LEN_W-1:0] corr_length;
    } ctrl_chan_t;

    typedef union packed {
        ctrl_global_t gbl;
        ctrl_chan_t   chan;
    } ctrl_word_u;

endpackage

// ==== despreader_regs/despreader_regs.sv ====
/* despreader register set
   byte-lane writable configuration for both code channels, global
   mode and dwell control, read mux, and the slip request to each
   code generator. */
`timescale 1ns/1ps

module despreader_regs (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            cs,
    input  logic [3:0]                      wr,
    input  logic [despread_pkg::ADDR_W-1:0] addr,
    input  logic [despread_pkg::DATA_W-1:0] din,
    output logic [despread_pkg::DATA_W-1:0] dout,
    code_cfg_if.regs                        cfg_a,
    code_cfg_if.regs                        cfg_b
);

    localparam int W  = despread_pkg::LFSR_W;
    localparam int AW = despread_pkg::ADDR_W;
    localparam int DW = despread_pkg::DATA_W;

    // index 0 is channel a.
    localparam logic [1:0][AW-1:0] A_INIT =
        {despread_pkg::ADDR_INIT_B, despread_pkg::ADDR_INIT_A};
    localparam logic [1:0][AW-1:0] A_POLY =
        {despread_pkg::ADDR_POLY_TAPS_B, despread_pkg::ADDR_POLY_TAPS_A};
    localparam logic [1:0][AW-1:0] A_RESTART =
        {despread_pkg::ADDR_RESTART_COUNT_B, despread_pkg::ADDR_RESTART_COUNT_A};
    localparam logic [1:0][AW-1:0] A_IOUT =
        {despread_pkg::ADDR_I_OUT_TAPS_B, despread_pkg::ADDR_I_OUT_TAPS_A};
    localparam logic [1:0][AW-1:0] A_QOUT =
        {despread_pkg::ADDR_Q_OUT_TAPS_B, despread_pkg::ADDR_Q_OUT_TAPS_A};
    localparam logic [1:0][AW-1:0] A_CTRL =
        {despread_pkg::ADDR_CONTROL_B, despread_pkg::ADDR_CONTROL_A};
    localparam logic [1:0][AW-1:0] A_EPOCH =
        {despread_pkg::ADDR_EPOCH_B, despread_pkg::ADDR_EPOCH_A};

    logic [1:0][W-1:0]                      init_r, poly_r, restart_r;
    logic [1:0][W-1:0]                      iout_r, qout_r, epoch_r;
    logic [1:0][despread_pkg::CORR_LEN_W-1:0] corr_len_r;
    logic [1:0]                             slip_req, slip_ack;
    despread_pkg::despread_mode_e           mode_r;
    logic [despread_pkg::DWELL_W-1:0]       dwell_r;
    logic                                   manual_slip_r;
    despread_pkg::ctrl_word_u               wdata, rdata;

    // 18-bit field, bits 17:16 sit in byte lane 2.
    function automatic logic [W-1:0] lane_wr(input logic [W-1:0] cur,
                                             input logic [3:0] be,
                                             input logic [DW-1:0] d);
        lane_wr = cur;
        if (be[0]) lane_wr[7:0] = d[7:0];
        if (be[1]) lane_wr[15:8] = d[15:8];
        if (be[2]) lane_wr[W-1:16] = d[W-1:16];
    endfunction

    function automatic logic [DW-1:0] zext(input logic [W-1:0] f);
        zext = {{(DW - W){1'b0}}, f};
    endfunction

    assign wdata = din;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_r        <= '0;
            poly_r        <= '0;
            restart_r     <= '0;
            iout_r        <= '0;
            qout_r        <= '0;
            epoch_r       <= '0;
            corr_len_r    <= '0;
            mode_r        <= despread_pkg::MODE_OFF;
            dwell_r       <= '0;
            manual_slip_r <= 1'b0;
        end else if (cs) begin
            for (int ch = 0; ch < 2; ch++) begin
                if (addr == A_INIT[ch]) init_r[ch] <= lane_wr(init_r[ch], wr, din);
                if (addr == A_POLY[ch]) poly_r[ch] <= lane_wr(poly_r[ch], wr, din);
                if (addr == A_RESTART[ch]) restart_r[ch] <= lane_wr(restart_r[ch], wr, din);
                if (addr == A_IOUT[ch]) iout_r[ch] <= lane_wr(iout_r[ch], wr, din);
                if (addr == A_QOUT[ch]) qout_r[ch] <= lane_wr(qout_r[ch], wr, din);
                if (addr == A_EPOCH[ch]) epoch_r[ch] <= lane_wr(epoch_r[ch], wr, din);
                if (addr == A_CTRL[ch] && wr[0]) corr_len_r[ch] <= wdata.chan.corr_length;
            end
            if (addr == despread_pkg::ADDR_CONTROL) begin
                if (wr[0]) mode_r <= wdata.gbl.despread_mode;
                if (wr[1]) dwell_r <= wdata.gbl.dwell_count;
                if (wr[3]) manual_slip_r <= wdata.gbl.manual_slip;
            end
        end
    end

    // four-phase slip request, a write while busy is dropped.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slip_req <= '0;
        end else begin
            for (int ch = 0; ch < 2; ch++) begin
                if (slip_ack[ch]) begin
                    slip_req[ch] <= 1'b0;
                end else if (cs && wr[3] && addr == A_CTRL[ch]) begin
                    slip_req[ch] <= 1'b1;
                end
            end
        end
    end

    always_comb begin
        rdata = '0;
        if (cs) begin
            if (addr == despread_pkg::ADDR_CONTROL) begin
                rdata.gbl.manual_slip   = manual_slip_r;
                rdata.gbl.dwell_count   = dwell_r;
                rdata.gbl.despread_mode = mode_r;
            end
            for (int ch = 0; ch < 2; ch++) begin
                if (addr == A_INIT[ch]) rdata = zext(init_r[ch]);
                if (addr == A_POLY[ch]) rdata = zext(poly_r[ch]);
                if (addr == A_RESTART[ch]) rdata = zext(restart_r[ch]);
                if (addr == A_IOUT[ch]) rdata = zext(iout_r[ch]);
                if (addr == A_QOUT[ch]) rdata = zext(qout_r[ch]);
                if (addr == A_EPOCH[ch]) rdata = zext(epoch_r[ch]);
                if (addr == A_CTRL[ch]) rdata.chan.corr_length = corr_len_r[ch];
            end
        end
    end

    assign dout     = rdata;
    assign slip_ack = {cfg_b.slip_ack, cfg_a.slip_ack};

    assign cfg_a.init          = init_r[0];
    assign cfg_a.poly_taps     = poly_r[0];
    assign cfg_a.restart_count = restart_r[0];
    assign cfg_a.i_out_taps    = iout_r[0];
    assign cfg_a.q_out_taps    = qout_r[0];
    assign cfg_a.epoch         = epoch_r[0];
    assign cfg_a.corr_length   = corr_len_r[0];
    assign cfg_a.dwell_count   = dwell_r;
    assign cfg_a.manual_slip   = manual_slip_r;
    assign cfg_a.slip_req      = slip_req[0];
    assign cfg_a.enable        = mode_r == despread_pkg::MODE_A ||
                                 mode_r == despread_pkg::MODE_BOTH;

    assign cfg_b.init          = init_r[1];
    assign cfg_b.poly_taps     = poly_r[1];
    assign cfg_b.restart_count = restart_r[1];
    assign cfg_b.i_out_taps    = iout_r[1];
    assign cfg_b.q_out_taps    = qout_r[1];
    assign cfg_b.epoch         = epoch_r[1];
    assign cfg_b.corr_length   = corr_len_r[1];
    assign cfg_b.dwell_count   = dwell_r;
    assign cfg_b.manual_slip   = manual_slip_r;
    assign cfg_b.slip_req      = slip_req[1];
    assign cfg_b.enable        = mode_r == despread_pkg::MODE_B ||
                                 mode_r == despread_pkg::MODE_BOTH;

endmodule

// ==== despreader_top.f ====
+incdir+bench
common/despread_pkg.sv
common/code_cfg_if.sv
despreader_regs/despreader_regs.sv
code_gen/code_gen.sv
hdl/correlator.sv
hdl/despreader_top.sv
bench/tb_despreader_top.sv

// ==== hdl/correlator.sv ====
/* correlator
   strips the code from one channel's I/Q samples by sign flip and
   dumps the integrated sums at the end of each period. */
`timescale 1ns/1ps

module correlator #(
    parameter int ACC_W = 24
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     enable,
    input  logic                                     chip_valid,
    input  logic                                     chip_i,
    input  logic                                     chip_q,
    input  logic                                     dump,
    input  logic signed [despread_pkg::SAMPLE_W-1:0] sample_i,
    input  logic signed [despread_pkg::SAMPLE_W-1:0] sample_q,
    output logic                                     corr_valid,
    output logic signed [ACC_W-1:0]                  corr_i,
    output logic signed [ACC_W-1:0]                  corr_q
);

    logic signed [ACC_W-1:0] acc_i, acc_q, sum_i, sum_q;

    // chip of one means times minus one.
    assign sum_i = acc_i + (chip_i ? -ACC_W'(sample_i) : ACC_W'(sample_i));
    assign sum_q = acc_q + (chip_q ? -ACC_W'(sample_q) : ACC_W'(sample_q));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            acc_i      <= '0;
            acc_q      <= '0;
            corr_valid <= 1'b0;
        end else if (!enable) begin
            acc_i      <= '0;
            acc_q      <= '0;
            corr_valid <= 1'b0;
        end else begin
            corr_valid <= chip_valid && dump;
            if (chip_valid) begin
                acc_i <= dump ? '0 : sum_i;  // restart after dump.
                acc_q <= dump ? '0 : sum_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (chip_valid && dump) begin
            corr_i <= sum_i;
            corr_q <= sum_q;
        end
    end

endmodule

// ==== hdl/despreader_top.sv ====
/* two-channel despreader
   register set, one code generator and one correlator per channel,
   sharing the incoming I/Q sample stream. */
`timescale 1ns/1ps

module despreader_top #(
    parameter int ACC_W = 24
) (
    input  logic                                     clk,
    input  logic                                     arst_n,
    input  logic                                     cs,
    input  logic [3:0]                               wr,
    input  logic [despread_pkg::ADDR_W-1:0]          addr,
    input  logic [despread_pkg::DATA_W-1:0]          din,
    output logic [despread_pkg::DATA_W-1:0]          dout,
    input  logic                                     sample_valid,
    input  logic signed [despread_pkg::SAMPLE_W-1:0] sample_i,
    input  logic signed [despread_pkg::SAMPLE_W-1:0] sample_q,
    output logic                                     corr_valid_a,
    output logic signed [ACC_W-1:0]                  corr_i_a,
    output logic signed [ACC_W-1:0]                  corr_q_a,
    output logic                                     epoch_a,
    output logic                                     corr_valid_b,
    output logic signed [ACC_W-1:0]                  corr_i_b,
    output logic signed [ACC_W-1:0]                  corr_q_b,
    output logic                                     epoch_b
);

    logic                                     chip_valid_a, chip_i_a, chip_q_a, dump_a;
    logic                                     chip_valid_b, chip_i_b, chip_q_b, dump_b;
    logic signed [despread_pkg::SAMPLE_W-1:0] smp_i_a, smp_q_a, smp_i_b, smp_q_b;

    code_cfg_if cfg_a ();
    code_cfg_if cfg_b ();

    despreader_regs i_despreader_regs (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (cs),
        .wr     (wr),
        .addr   (addr),
        .din    (din),
        .dout   (dout),
        .cfg_a  (cfg_a.regs),
        .cfg_b  (cfg_b.regs)
    );

    code_gen i_code_gen_a (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg          (cfg_a.gen),
        .sample_valid (sample_valid),
        .sample_i_in  (sample_i),
        .sample_q_in  (sample_q),
        .chip_valid   (chip_valid_a),
        .chip_i       (chip_i_a),
        .chip_q       (chip_q_a),
        .dump         (dump_a),
        .epoch        (epoch_a),
        .sample_i     (smp_i_a),
        .sample_q     (smp_q_a)
    );

    code_gen i_code_gen_b (
        .clk          (clk),
        .arst_n       (arst_n),
        .cfg          (cfg_b.gen),
        .sample_valid (sample_valid),
        .sample_i_in  (sample_i),
        .sample_q_in  (sample_q),
        .chip_valid   (chip_valid_b),
        .chip_i       (chip_i_b),
        .chip_q       (chip_q_b),
        .dump         (dump_b),
        .epoch        (epoch_b),
        .sample_i     (smp_i_b),
        .sample_q     (smp_q_b)
    );

    correlator #(.ACC_W(ACC_W)) i_correlator_a (
        .clk        (clk),
        .arst_n     (arst_n),
        .enable     (cfg_a.enable),
        .chip_valid (chip_valid_a),
        .chip_i     (chip_i_a),
        .chip_q     (chip_q_a),
        .dump       (dump_a),
        .sample_i   (smp_i_a),
        .sample_q   (smp_q_a),
        .corr_valid (corr_valid_a),
        .corr_i     (corr_i_a),
        .corr_q     (corr_q_a)
    );

    correlator #(.ACC_W(ACC_W)) i_correlator_b (
        .clk        (clk),
        .arst_n     (arst_n),
        .enable     (cfg_b.enable),
        .chip_valid (chip_valid_b),
        .chip_i     (chip_i_b),
        .chip_q     (chip_q_b),
        .dump       (dump_b),
        .sample_i   (smp_i_b),
        .sample_q   (smp_q_b),
        .corr_valid (corr_valid_b),
        .corr_i     (corr_i_b),
        .corr_q     (corr_q_b)
    );

endmodule
